// File: hdl/ee_pkg.sv
package ee_pkg;

	// Array geometry of the 93C46 in x16 mode
	localparam int EE_ADDR_W  = 6;                          // Word address bits
	localparam int EE_DATA_W  = 16;                         // Bits per word
	localparam int EE_WORDS   = 64;                         // 1 << EE_ADDR_W
	localparam int EE_INSTR_W = 9;                          // Start + opcode + address

	localparam logic [EE_DATA_W-1:0] EE_ERASED = {EE_DATA_W{1'b1}};  // Erased cells read high

	// Opcodes that follow the start bit
	localparam logic [1:0] EE_OP_READ  = 2'b10;
	localparam logic [1:0] EE_OP_WRITE = 2'b01;
	localparam logic [1:0] EE_OP_ERASE = 2'b11;
	localparam logic [1:0] EE_OP_EXT   = 2'b00;             // Address field carries a subcode

	// Subcodes in the top two address bits under EE_OP_EXT
	localparam logic [1:0] EE_EXT_EWDS = 2'b00;             // Write disable
	localparam logic [1:0] EE_EXT_WRAL = 2'b01;             // Write all
	localparam logic [1:0] EE_EXT_ERAL = 2'b10;             // Erase all
	localparam logic [1:0] EE_EXT_EWEN = 2'b11;             // Write enable

	// One instruction word seen two ways
	typedef union packed {
		struct packed {
			logic                 start;                    // Always 1 once aligned
			logic [1:0]           op;
			logic [EE_ADDR_W-1:0] addr;                     // Target word
		} adr;
		struct packed {
			logic       start;
			logic [1:0] op;                                 // EE_OP_EXT here
			logic [1:0] code;                               // EWEN/EWDS/WRAL/ERAL
			logic [3:0] dc;                                 // Ignored by the part
		} ext;
	} ee_instr_u;

endpackage

// File: hdl/ee_word_store.sv
`timescale 1ns/1ps

module ee_word_store import ee_pkg::*; (
	input  logic                 sys_clk,
	input  logic [EE_ADDR_W-1:0] rd_addr_i,
	input  logic                 we_i,        // Single-cycle write strobe
	input  logic [EE_ADDR_W-1:0] wr_addr_i,
	input  logic [EE_DATA_W-1:0] wr_data_i,
	output logic [EE_DATA_W-1:0] rd_data_o    // Valid one cycle after rd_addr_i
);

	// Nonvolatile array, contents survive reset
	logic [EE_DATA_W-1:0] mem [EE_WORDS];

	// Write port
	always_ff @(posedge sys_clk) begin
		if (we_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge sys_clk) begin
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

// File: hdl/ee_write_sequencer.sv
`timescale 1ns/1ps

module ee_write_sequencer import ee_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 xresetl,
	input  logic                 wr_start_i,   // Strobe from the serial front
	input  logic [EE_ADDR_W-1:0] wr_addr_i,
	input  logic [EE_DATA_W-1:0] wr_data_i,    // Already EE_ERASED for erases
	input  logic                 wr_all_i,     // Sweep the whole array
	input  logic                 wr_enable_i,  // Write-enable latch
	output logic                 busy_o,
	output logic                 mem_we_o,
	output logic [EE_ADDR_W-1:0] mem_addr_o,
	output logic [EE_DATA_W-1:0] mem_data_o
);

	// Sequencer states
	localparam logic [2:0] SQ_IDLE  = 3'd0;
	localparam logic [2:0] SQ_BEGIN = 3'd1;  // Address setup
	localparam logic [2:0] SQ_WRITE = 3'd2;  // First or only write
	localparam logic [2:0] SQ_LOOP  = 3'd3;  // Remaining words of WRAL/ERAL
	localparam logic [2:0] SQ_END   = 3'd4;  // Last busy cycle

	logic [2:0] state;
	logic       all_q;    // Whole array pass
	logic       en_q;     // Enable as seen at start

	// Busy for the whole sequence, 3 cycles single, 66 for all words
	assign busy_o = (state != SQ_IDLE);

	// Sequence still runs with writes disabled, only the strobe is held off
	assign mem_we_o = en_q & ((state == SQ_WRITE) | (state == SQ_LOOP));

	always_ff @(posedge sys_clk) begin
		if (~xresetl) begin
			state <= SQ_IDLE;
			en_q  <= 1'b0;
		end else begin
			case (state)
				SQ_IDLE: begin
					if (wr_start_i) begin
						state      <= SQ_BEGIN;
						en_q       <= wr_enable_i;
						all_q      <= wr_all_i;
						mem_addr_o <= wr_addr_i;
						mem_data_o <= wr_data_i;
					end
				end
				SQ_BEGIN: begin
					if (all_q) begin
						mem_addr_o <= '0;              // Sweep starts at word 0
					end
					state <= SQ_WRITE;
				end
				SQ_WRITE: begin
					if (all_q) begin
						mem_addr_o <= mem_addr_o + 1'b1;
						state      <= SQ_LOOP;
					end else begin
						state <= SQ_END;
					end
				end
				SQ_LOOP: begin
					if (mem_addr_o == EE_ADDR_W'(EE_WORDS - 1)) begin
						state <= SQ_END;               // Word 63 written this cycle
					end else begin
						mem_addr_o <= mem_addr_o + 1'b1;
					end
				end
				SQ_END: begin
					state <= SQ_IDLE;
					en_q  <= 1'b0;
				end
				default: state <= SQ_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/ee_serial_front.sv
`timescale 1ns/1ps

module ee_serial_front import ee_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 xresetl,
	input  logic                 cs_i,        // Chip select, high active
	input  logic                 sk_i,        // Serial clock, slow
	input  logic                 di_i,        // Serial data in
	input  logic                 busy_i,      // Internal write in progress
	input  logic [EE_DATA_W-1:0] rd_data_i,   // Store output, one cycle after rd_addr_o
	output logic                 do_o,        // Serial data out
	output logic [EE_ADDR_W-1:0] rd_addr_o,
	output logic                 wr_start_o,  // One-cycle strobe to the sequencer
	output logic [EE_ADDR_W-1:0] wr_addr_o,
	output logic [EE_DATA_W-1:0] wr_data_o,
	output logic                 wr_all_o,    // WRAL or ERAL
	output logic                 wr_enable_o  // Write-enable latch (EWEN/EWDS)
);

	// Front end states
	localparam logic [1:0] ST_INSTR = 2'd0;  // Waiting for start bit and opcode
	localparam logic [1:0] ST_DATA  = 2'd1;  // Collecting the write word
	localparam logic [1:0] ST_READ  = 2'd2;  // Shifting read data out
	localparam logic [1:0] ST_DONE  = 2'd3;  // Command taken, wait for cs low

	logic                 sk_prev;
	logic                 sk_rise;
	logic [1:0]           state;
	ee_instr_u            ir;        // Instruction shifter
	ee_instr_u            ir_next;   // Shifter with the current bit in
	logic [3:0]           cnt;       // Data bit counter
	logic [EE_DATA_W-1:0] dr;        // Data in / read out shifter
	logic                 rd_load;   // Store word arrives this cycle
	logic                 do_r;

	assign sk_rise = sk_i & ~sk_prev;
	assign ir_next = {ir[EE_INSTR_W-2:0], di_i};

	// Address is live on the last address edge, store registers it there
	assign rd_addr_o = ir_next.adr.addr;

	// Busy low while selected, idle high when deselected
	assign do_o = ~cs_i | (~busy_i & do_r);

	always_ff @(posedge sys_clk) begin
		sk_prev    <= sk_i;
		wr_start_o <= 1'b0;
		rd_load    <= 1'b0;
		if (~xresetl) begin
			state       <= ST_INSTR;
			ir          <= '0;
			cnt         <= '0;
			do_r        <= 1'b1;
			wr_enable_o <= 1'b0;
		end else if (~cs_i || busy_i) begin
			// Deselect or running write drops any partial command
			state <= ST_INSTR;
			ir    <= '0;
			cnt   <= '0;
			dr    <= '0;
			do_r  <= 1'b1;
		end else if (sk_rise) begin
			case (state)
				ST_INSTR: begin
					ir <= ir_next;
					if (ir_next.adr.start) begin          // Start bit at the top
						ir        <= '0;
						wr_addr_o <= ir_next.adr.addr;
						wr_all_o  <= 1'b0;
						state     <= ST_DONE;
						case (ir_next.adr.op)
							EE_OP_READ: begin
								state   <= ST_READ;
								do_r    <= 1'b0;          // Dummy zero
								rd_load <= 1'b1;
							end
							EE_OP_WRITE: state <= ST_DATA;
							EE_OP_ERASE: begin
								wr_data_o  <= EE_ERASED;
								wr_start_o <= 1'b1;
							end
							EE_OP_EXT: begin
								case (ir_next.ext.code)
									EE_EXT_EWEN: wr_enable_o <= 1'b1;
									EE_EXT_EWDS: wr_enable_o <= 1'b0;
									EE_EXT_WRAL: begin
										wr_all_o <= 1'b1;
										state    <= ST_DATA;
									end
									EE_EXT_ERAL: begin
										wr_all_o   <= 1'b1;
										wr_data_o  <= EE_ERASED;
										wr_start_o <= 1'b1;
									end
								endcase
							end
						endcase
					end
				end
				ST_DATA: begin
					dr  <= {dr[EE_DATA_W-2:0], di_i};   // MSB first
					cnt <= cnt + 4'd1;
					if (cnt == 4'(EE_DATA_W - 1)) begin
						wr_data_o  <= {dr[EE_DATA_W-2:0], di_i};
						wr_start_o <= 1'b1;
						state      <= ST_DONE;
					end
				end
				ST_READ: begin
					do_r <= dr[EE_DATA_W-1];
					dr   <= {dr[EE_DATA_W-2:0], 1'b0};   // Zeros after the last bit
				end
				default: ;                                // ST_DONE holds until deselect
			endcase
		end else if (rd_load) begin
			dr <= rd_data_i;                              // Read word into the shifter
		end
	end

endmodule

// File: hdl/eeprom_93c46.sv
`timescale 1ns/1ps

module eeprom_93c46 import ee_pkg::*; (
	input  logic sys_clk,
	input  logic xresetl,
	input  logic cs_i,   // Chip select
	input  logic sk_i,   // Serial clock
	input  logic di_i,   // Serial data in
	output logic do_o    // Serial data out, low while busy
);

	logic [EE_ADDR_W-1:0] rd_addr;
	logic [EE_DATA_W-1:0] rd_data;
	logic                 busy;
	logic                 wr_start;
	logic [EE_ADDR_W-1:0] wr_addr;
	logic [EE_DATA_W-1:0] wr_data;
	logic                 wr_all;
	logic                 wr_enable;
	logic                 mem_we;
	logic [EE_ADDR_W-1:0] mem_addr;
	logic [EE_DATA_W-1:0] mem_data;

	// Serial protocol side
	ee_serial_front u_front (
		.sys_clk     (sys_clk),
		.xresetl     (xresetl),
		.cs_i        (cs_i),
		.sk_i        (sk_i),
		.di_i        (di_i),
		.busy_i      (busy),
		.rd_data_i   (rd_data),
		.do_o        (do_o),
		.rd_addr_o   (rd_addr),
		.wr_start_o  (wr_start),
		.wr_addr_o   (wr_addr),
		.wr_data_o   (wr_data),
		.wr_all_o    (wr_all),
		.wr_enable_o (wr_enable)
	);

	// 64 x 16 array
	ee_word_store u_store (
		.sys_clk   (sys_clk),
		.rd_addr_i (rd_addr),
		.we_i      (mem_we),
		.wr_addr_i (mem_addr),
		.wr_data_i (mem_data),
		.rd_data_o (rd_data)
	);

	// Internal write timing
	ee_write_sequencer u_seq (
		.sys_clk     (sys_clk),
		.xresetl     (xresetl),
		.wr_start_i  (wr_start),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data),
		.wr_all_i    (wr_all),
		.wr_enable_i (wr_enable),
		.busy_o      (busy),
		.mem_we_o    (mem_we),
		.mem_addr_o  (mem_addr),
		.mem_data_o  (mem_data)
	);

endmodule

// File: verif/tb_eeprom_93c46.sv
`timescale 1ns/1ps

module tb_eeprom_93c46 import ee_pkg::*; ();

	localparam int SK_HALF   = 8;                       // sys_clk cycles per sk level
	localparam int READY_MAX = 200;                     // Ready poll limit in cycles
	localparam int N_CMDS    = 150;                     // Commands over all six tests
	localparam int CMD_BITS  = 40;                      // Longest command incl. select
	localparam int WD_NS     = 2 * N_CMDS * CMD_BITS * 2 * SK_HALF * 40;

	logic sys_clk;
	logic xresetl;
	logic cs_i;
	logic sk_i;
	logic di_i;
	logic do_o;

	logic [EE_DATA_W-1:0] model_mem [EE_WORDS];        // Expected array contents
	logic                 model_wen;                    // Expected write-enable latch
	logic [EE_ADDR_W-1:0] addr_q [$];                   // Addresses written in test 3
	integer               seed;
	int                   errors;
	int                   checks;
	int                   tests;
	int                   failed;
	int                   errs_at_start;

	eeprom_93c46 u_dut (
		.sys_clk (sys_clk),
		.xresetl (xresetl),
		.cs_i    (cs_i),
		.sk_i    (sk_i),
		.di_i    (di_i),
		.do_o    (do_o)
	);

	initial sys_clk = 1'b0;
	always #20 sys_clk = ~sys_clk;                     // 40 ns period

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic ee_instr_u addr_instr(input logic [1:0] op, input logic [EE_ADDR_W-1:0] a);
		ee_instr_u w;
		w.adr.start = 1'b1;
		w.adr.op    = op;
		w.adr.addr  = a;
		return w;
	endfunction

	function automatic ee_instr_u ext_instr(input logic [1:0] code);
		ee_instr_u w;
		w.ext.start = 1'b1;
		w.ext.op    = EE_OP_EXT;
		w.ext.code  = code;
		w.ext.dc    = 4'h0;                             // Don't care on the bus
		return w;
	endfunction

	function automatic string cmd_name(input ee_instr_u w);
		case (w.adr.op)
			EE_OP_READ:  return "READ";
			EE_OP_WRITE: return "WRITE";
			EE_OP_ERASE: return "ERASE";
			default: begin
				case (w.ext.code)
					EE_EXT_EWEN: return "EWEN";
					EE_EXT_EWDS: return "EWDS";
					EE_EXT_WRAL: return "WRAL";
					default:     return "ERAL";
				endcase
			end
		endcase
	endfunction

	function automatic logic has_data(input ee_instr_u w);
		return (w.adr.op == EE_OP_WRITE) || (w.adr.op == EE_OP_EXT && w.ext.code == EE_EXT_WRAL);
	endfunction

	// Reference rules, array and latch updated per completed command
	function automatic void model_apply(input ee_instr_u w, input logic [EE_DATA_W-1:0] data);
		case (w.adr.op)
			EE_OP_WRITE: if (model_wen) model_mem[w.adr.addr] = data;
			EE_OP_ERASE: if (model_wen) model_mem[w.adr.addr] = EE_ERASED;
			EE_OP_EXT: begin
				case (w.ext.code)
					EE_EXT_EWEN: model_wen = 1'b1;
					EE_EXT_EWDS: model_wen = 1'b0;
					default: begin                      // WRAL or ERAL
						for (int i = 0; i < EE_WORDS; i++) begin
							if (model_wen) begin
								model_mem[EE_ADDR_W'(i)] = (w.ext.code == EE_EXT_WRAL) ? data : EE_ERASED;
							end
						end
					end
				endcase
			end
			default: ;                                  // READ changes nothing
		endcase
	endfunction

	// Wait n clocks, land 2 ns past the edge
	task automatic tick(input int n);
		repeat (n) begin
			@(posedge sys_clk);
			#2;
		end
	endtask

	// One serial bit, do_o sampled late in the high phase
	task automatic clock_bit(input logic b, output logic q);
		di_i = b;
		sk_i = 1'b0;
		tick(SK_HALF);
		sk_i = 1'b1;
		tick(SK_HALF);
		q = do_o;
	endtask

	task automatic select_chip();
		sk_i = 1'b0;
		cs_i = 1'b1;
		tick(4);
	endtask

	task automatic deselect_chip();
		sk_i = 1'b0;
		di_i = 1'b0;
		cs_i = 1'b0;
		tick(4);
	endtask

	// Shift out the top n instruction bits, MSB first
	task automatic send_bits(input ee_instr_u w, input int n, output logic q);
		logic [EE_INSTR_W-1:0] bits;
		bits = w;
		repeat (n) begin
			clock_bit(bits[EE_INSTR_W-1], q);
			bits = bits << 1;
		end
	endtask

	task automatic wait_ready(input ee_instr_u w);
		int n;
		n = 0;
		while (do_o !== 1'b1 && n < READY_MAX) begin
			tick(1);
			n++;
		end
		checks++;
		assert (do_o === 1'b1) else begin
			$display("Ready never returned on do_o within %0d cycles after %s", READY_MAX, cmd_name(w));
			errors++;
		end
	endtask

	// Full command with status poll, then model update
	task automatic run_cmd(input ee_instr_u w, input logic [EE_DATA_W-1:0] data, input logic busy_exp);
		logic                 q;
		logic [EE_DATA_W-1:0] sh;
		sh = data;
		select_chip();
		send_bits(w, EE_INSTR_W, q);
		if (has_data(w)) begin
			repeat (EE_DATA_W) begin
				clock_bit(sh[EE_DATA_W-1], q);
				sh = sh << 1;
			end
		end
		if (busy_exp) begin
			checks++;
			assert (q === 1'b0) else begin
				$display("FAIL do_o busy after %s: exp 0 got %h", cmd_name(w), q);
				errors++;
			end
		end
		wait_ready(w);
		deselect_chip();
		model_apply(w, data);
	endtask

	// READ one word, check the dummy zero, compare with the model
	task automatic compare_word(input logic [EE_ADDR_W-1:0] a);
		logic                 q;
		logic [EE_DATA_W-1:0] got;
		got = '0;
		select_chip();
		send_bits(addr_instr(EE_OP_READ, a), EE_INSTR_W, q);
		checks++;
		assert (q === 1'b0) else begin
			$display("FAIL do_o dummy bit at %h: exp 0 got %h", a, q);
			errors++;
		end
		repeat (EE_DATA_W) begin
			clock_bit(1'b0, q);
			got = {got[EE_DATA_W-2:0], q};              // MSB arrives first
		end
		deselect_chip();
		checks++;
		assert (got === model_mem[a]) else begin
			$display("FAIL rd_word[%h]: exp %h got %h", a, model_mem[a], got);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == errs_at_start) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: %0d errors", tests, name, errors - errs_at_start);
		end
		errs_at_start = errors;
	endtask

	initial begin
		logic [EE_ADDR_W-1:0] a;
		logic [EE_DATA_W-1:0] d;
		logic                 q;
		seed          = 32'he6e0209a;
		xresetl       = 1'b0;
		cs_i          = 1'b0;
		sk_i          = 1'b0;
		di_i          = 1'b0;
		model_wen     = 1'b0;
		errors        = 0;
		checks        = 0;
		tests         = 0;
		failed        = 0;
		errs_at_start = 0;
		tick(3);                                        // Reset over 3 edges
		xresetl = 1'b1;
		tick(2);

		// 1 Idle level after reset
		select_chip();
		checks++;
		assert (do_o === 1'b1) else begin
			$display("FAIL do_o after reset: exp 1 got %h", do_o);
			errors++;
		end
		deselect_chip();
		end_test("reset idle");

		// 2 Enable, erase all, then disabled write has no effect
		run_cmd(ext_instr(EE_EXT_EWEN), '0, 1'b0);
		run_cmd(ext_instr(EE_EXT_ERAL), '0, 1'b1);
		repeat (5) compare_word(EE_ADDR_W'(next_rand()));
		run_cmd(ext_instr(EE_EXT_EWDS), '0, 1'b0);
		a = EE_ADDR_W'(next_rand());
		run_cmd(addr_instr(EE_OP_WRITE, a), EE_DATA_W'(next_rand()), 1'b0);
		compare_word(a);
		end_test("write protect");

		// 3 Random word writes
		run_cmd(ext_instr(EE_EXT_EWEN), '0, 1'b0);
		repeat (16) begin
			a = EE_ADDR_W'(next_rand());
			d = EE_DATA_W'(next_rand());
			addr_q.push_back(a);
			run_cmd(addr_instr(EE_OP_WRITE, a), d, 1'b0);
		end
		foreach (addr_q[i]) compare_word(addr_q[i]);
		end_test("word write");

		// 4 Single erase, neighbours intact
		run_cmd(addr_instr(EE_OP_ERASE, addr_q[0]), '0, 1'b0);
		foreach (addr_q[i]) compare_word(addr_q[i]);
		end_test("word erase");

		// 5 Write all with one random word
		run_cmd(ext_instr(EE_EXT_WRAL), EE_DATA_W'(next_rand()), 1'b1);
		for (int i = 0; i < EE_WORDS; i++) compare_word(EE_ADDR_W'(i));
		end_test("write all");

		// 6 Deselect mid instruction, then a clean WRITE
		a = EE_ADDR_W'(next_rand());
		select_chip();
		send_bits(addr_instr(EE_OP_WRITE, a), 5, q);   // Start, opcode, two address bits
		deselect_chip();
		compare_word(a);
		run_cmd(addr_instr(EE_OP_WRITE, a), EE_DATA_W'(next_rand()), 1'b0);
		compare_word(a);
		end_test("cs abort");

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Run limit from command count, bits and bit time, doubled
	initial begin
		#(WD_NS);
		$display("Watchdog expired after %0d ns, run stopped", WD_NS);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: project.f
hdl/ee_pkg.sv
hdl/ee_word_store.sv
hdl/ee_write_sequencer.sv
hdl/ee_serial_front.sv
hdl/eeprom_93c46.sv
verif/tb_eeprom_93c46.sv

// File: Makefile
# Verilator build and run for the 93C46 EEPROM model

VERILATOR  ?= verilator
TOP        ?= tb_eeprom_93c46
RTL_TOP    ?= eeprom_93c46
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= ^>>> PASS$$

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(BIN) | tee $(LOG)
	@if grep -q '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
